//--- list.f
+incdir+bench
hw/dcache_pkg.sv
hw/dcache_sdp_ram.sv
hw/dcache_valid_dirty.sv
hw/dcache_word_merge.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
bench/tb_dcache.sv

//--- bench/tb_dcache_model.svh
`ifndef TB_DCACHE_MODEL_SVH
`define TB_DCACHE_MODEL_SVH

// the tests stay inside the first 4 KiB, one array slot per word.
localparam int mem_words = 1024;

// memory as the core sees it, with no cache in between.
logic [31:0] exp_mem [mem_words];
// what L2 holds; only writebacks change it.
logic [31:0] l2_mem [mem_words];

function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// start value of a word, a hash of its byte address.
function automatic logic [31:0] init_word(input logic [31:0] addr);
    logic [31:0] h;
    h = addr * 32'h9e3779b1;
    return h ^ (h >> 15) ^ 32'h3c6ef372;
endfunction

function automatic void init_model();
    for (int i = 0; i < mem_words; i++) begin
        exp_mem[i] = init_word(i * 4);
        l2_mem[i]  = exp_mem[i];
    end
endfunction

function automatic logic [line_width-1:0] l2_read_line(input logic [27:0] line_addr);
    logic [line_width-1:0] line;
    for (int w = 0; w < line_words; w++) begin
        line[w*word_width +: word_width] = l2_mem[(line_addr * line_words + w) % mem_words];
    end
    return line;
endfunction

function automatic void l2_write_line(input logic [27:0] line_addr,
                                      input logic [line_width-1:0] line);
    for (int w = 0; w < line_words; w++) begin
        l2_mem[(line_addr * line_words + w) % mem_words] = line[w*word_width +: word_width];
    end
endfunction

// byte lanes with a strobe take the new data.
function automatic logic [31:0] store_merge(input logic [31:0] old, input logic [31:0] wdata,
                                           input logic [3:0] wstrb);
    logic [31:0] result;
    result = old;
    for (int b = 0; b < 4; b++) begin
        if (wstrb[b]) begin
            result[b*8 +: 8] = wdata[b*8 +: 8];
        end
    end
    return result;
endfunction

function automatic logic [31:0] amo_result(input amo_op_e op, input logic [31:0] old,
                                          input logic [31:0] operand);
    case (op)
        amo_swap: return operand;
        amo_add:  return old + operand;
        amo_and:  return old & operand;
        amo_or:   return old | operand;
        amo_xor:  return old ^ operand;
        amo_min:  return ($signed(old) <= $signed(operand)) ? old : operand;
        amo_max:  return ($signed(old) >= $signed(operand)) ? old : operand;
        amo_minu: return (old <= operand) ? old : operand;
        amo_maxu: return (old >= operand) ? old : operand;
        default:  return old;
    endcase
endfunction

`endif

//--- bench/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int addr_width   = 32;
    localparam int word_width   = 32;
    localparam int line_words   = 4;
    localparam int num_lines    = 64;
    localparam int line_width   = word_width * line_words;
    localparam int offset_width = $clog2(line_words * word_width / 8);
    localparam int n_loads      = 40;
    localparam int n_stores     = 40;
    localparam int n_amo_each   = 4;
    localparam int n_evict      = 6;
    localparam int n_hits       = 8;
    // each store and atomic is followed by a load of its word.
    // an eviction round also reloads its four words.
    localparam int total_requests = n_loads + 2 * n_stores + 2 * 9 * n_amo_each
        + 3 * 4 * n_evict + 2 * n_hits;
    localparam int cycle_limit  = total_requests * 40 + 20;

    logic                               CLK;
    logic                               RST;
    logic                               req_valid;
    req_cmd_e                           req_cmd;
    amo_op_e                            req_amo;
    logic [addr_width-1:0]              req_addr;
    logic [word_width-1:0]              req_wdata;
    logic [word_width/8-1:0]            req_wstrb;
    logic                               ready;
    logic                               rsp_valid;
    logic [word_width-1:0]              rsp_data;
    logic                               l2_wr_valid;
    logic [addr_width-offset_width-1:0] l2_wr_addr;
    logic [line_width-1:0]              l2_wr_data;
    logic                               l2_wr_done;
    logic                               l2_rd_valid;
    logic [addr_width-offset_width-1:0] l2_rd_addr;
    logic                               l2_rd_data_valid;
    logic [line_width-1:0]              l2_rd_data;

    logic [31:0] stim_seed;
    logic [31:0] l2_seed;
    int          check_count;
    int          error_count;
    int          test_checks;
    int          test_errors;
    int          cycle_count;
    string       test_name;

    `include "tb_dcache_model.svh"

    dcache_top #(
        .addr_width (addr_width),
        .word_width (word_width),
        .line_words (line_words),
        .num_lines  (num_lines)
    ) u_dcache_top (
        .CLK              (CLK),
        .RST              (RST),
        .req_valid        (req_valid),
        .req_cmd          (req_cmd),
        .req_amo          (req_amo),
        .req_addr         (req_addr),
        .req_wdata        (req_wdata),
        .req_wstrb        (req_wstrb),
        .ready            (ready),
        .rsp_valid        (rsp_valid),
        .rsp_data         (rsp_data),
        .l2_wr_valid      (l2_wr_valid),
        .l2_wr_addr       (l2_wr_addr),
        .l2_wr_data       (l2_wr_data),
        .l2_wr_done       (l2_wr_done),
        .l2_rd_valid      (l2_rd_valid),
        .l2_rd_addr       (l2_rd_addr),
        .l2_rd_data_valid (l2_rd_data_valid),
        .l2_rd_data       (l2_rd_data)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    //////////////////////////////
    // L2 responder
    //////////////////////////////

    always begin : l2_responder
        logic [27:0] line_addr;
        if (l2_wr_valid === 1'b1) begin
            l2_write_line(l2_wr_addr, l2_wr_data);
            l2_seed = lcg_next(l2_seed);
            repeat (int'(l2_seed[31:29]) + 1) @(negedge CLK);
            l2_wr_done = 1'b1;
            @(negedge CLK);
            l2_wr_done = 1'b0;
        end else if (l2_rd_valid === 1'b1) begin
            line_addr = l2_rd_addr;
            l2_seed = lcg_next(l2_seed);
            repeat (int'(l2_seed[31:29]) + 1) @(negedge CLK);
            l2_rd_data       = l2_read_line(line_addr);
            l2_rd_data_valid = 1'b1;
            @(negedge CLK);
            l2_rd_data_valid = 1'b0;
        end else begin
            @(negedge CLK);
        end
    end

    // hung run guard.
    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("Timeout: the DUT did not finish its requests within %0d cycles", cycle_limit);
        $display("Regression failed");
        $finish;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    function logic [31:0] stim_rand();
        stim_seed = lcg_next(stim_seed);
        return stim_seed;
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int idx, input int word);
        return (tag << 10) | (idx << 4) | (word << 2);
    endfunction

    // four tags over eight lines make conflicts common.
    function automatic logic [31:0] random_addr();
        logic [31:0] r;
        r = stim_rand();
        return make_addr(r[31:30], r[29:27], r[26:25]);
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error %s (%s): expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic finish_test();
        $display("test %-12s done: %0d checks, %0d errors", test_name,
                 check_count - test_checks, error_count - test_errors);
    endtask

    // one request from a falling edge to the falling edge after rsp_valid.
    task automatic access(input req_cmd_e cmd, input amo_op_e op, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] wstrb,
                          output logic [31:0] data, output int latency);
        latency = 0;
        while (ready !== 1'b1) @(negedge CLK);
        req_valid = 1'b1;
        req_cmd   = cmd;
        req_amo   = op;
        req_addr  = addr;
        req_wdata = wdata;
        req_wstrb = wstrb;
        @(negedge CLK);
        req_valid = 1'b0;
        while (rsp_valid !== 1'b1) begin
            @(negedge CLK);
            latency++;
        end
        data = rsp_data;
    endtask

    task automatic load_check(input logic [31:0] addr);
        logic [31:0] data;
        int          latency;
        access(cmd_load, amo_swap, addr, '0, '0, data, latency);
        check_value($sformatf("load %h", addr), exp_mem[addr[11:2]], data);
    endtask

    // store or atomic followed by a load of the same word.
    task automatic update_check(input req_cmd_e cmd, input amo_op_e op, input logic [31:0] addr,
                                input logic [31:0] wdata, input logic [3:0] wstrb);
        logic [31:0] data;
        logic [31:0] old;
        int          latency;
        old = exp_mem[addr[11:2]];
        access(cmd, op, addr, wdata, wstrb, data, latency);
        check_value($sformatf("old word %h", addr), old, data);
        if (cmd == cmd_store) begin
            exp_mem[addr[11:2]] = store_merge(old, wdata, wstrb);
        end else begin
            exp_mem[addr[11:2]] = amo_result(op, old, wdata);
        end
        load_check(addr);
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] r;
        int          latency;
        int          idx;
        RST              = 1'b1;
        req_valid        = 1'b0;
        req_cmd          = cmd_load;
        req_amo          = amo_swap;
        req_addr         = '0;
        req_wdata        = '0;
        req_wstrb        = '0;
        l2_wr_done       = 1'b0;
        l2_rd_data_valid = 1'b0;
        l2_rd_data       = '0;
        stim_seed        = 32'h571d3747;
        l2_seed          = 32'h571d3747 ^ 32'h0000ffff;
        check_count      = 0;
        error_count      = 0;
        init_model();

        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
        @(negedge CLK);

        start_test("reset");
        check_value("ready", 1, ready);
        check_value("rsp_valid", 0, rsp_valid);
        check_value("l2_rd_valid", 0, l2_rd_valid);
        check_value("l2_wr_valid", 0, l2_wr_valid);
        finish_test();

        start_test("loads");
        for (int i = 0; i < n_loads; i++) begin
            load_check(random_addr());
        end
        finish_test();

        start_test("stores");
        for (int i = 0; i < n_stores; i++) begin
            addr = random_addr();
            r    = stim_rand();
            update_check(cmd_store, amo_swap, addr, stim_rand(), r[31:28]);
        end
        finish_test();

        start_test("atomics");
        for (int k = 0; k < 9; k++) begin
            for (int j = 0; j < n_amo_each; j++) begin
                addr = random_addr();
                update_check(cmd_amo, amo_op_e'(k), addr, stim_rand(), 4'hf);
            end
        end
        finish_test();

        // four tags on one line; each store evicts the dirty one before it.
        start_test("evictions");
        for (int e = 0; e < n_evict; e++) begin
            idx = 16 + e;
            r   = stim_rand();
            for (int t = 0; t < 4; t++) begin
                addr = make_addr(t, idx, r[31:30]);
                update_check(cmd_store, amo_swap, addr, stim_rand(), 4'hf);
            end
            for (int t = 0; t < 4; t++) begin
                load_check(make_addr(t, idx, r[31:30]));
            end
        end
        finish_test();

        start_test("hit_timing");
        for (int h = 0; h < n_hits; h++) begin
            addr = random_addr();
            load_check(addr);
            access(cmd_load, amo_swap, addr, '0, '0, data, latency);
            check_value($sformatf("repeat load %h", addr), exp_mem[addr[11:2]], data);
            check_value("hit latency", 3, latency);
            check_value("ready with response", 1, ready);
        end
        finish_test();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- hw/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int addr_width = 32,
    parameter int word_width = 32,
    parameter int line_words = 4,
    parameter int num_lines  = 64,
    localparam int offset_width = $clog2(line_words * word_width / 8),
    localparam int index_width  = $clog2(num_lines),
    localparam int tag_width    = addr_width - index_width - offset_width,
    localparam int line_width   = word_width * line_words,
    localparam int sel_width    = (line_words > 1) ? $clog2(line_words) : 1
) (
    input  logic                           CLK,
    input  logic                           RST,
    input  logic                           req_valid,
    input  dcache_pkg::req_cmd_e           req_cmd,
    input  dcache_pkg::amo_op_e            req_amo,
    input  logic [addr_width-1:0]          req_addr,
    input  logic [word_width-1:0]          req_wdata,
    input  logic [word_width/8-1:0]        req_wstrb,
    output logic                           ready,
    output logic                           rsp_valid,
    output logic [word_width-1:0]          rsp_data,
    output logic                           l2_wr_valid,
    output logic [addr_width-offset_width-1:0] l2_wr_addr,
    output logic [line_width-1:0]          l2_wr_data,
    input  logic                           l2_wr_done,
    output logic                           l2_rd_valid,
    output logic [addr_width-offset_width-1:0] l2_rd_addr,
    input  logic                           l2_rd_data_valid,
    input  logic [line_width-1:0]          l2_rd_data
);
    import dcache_pkg::*;

    logic [index_width-1:0]  ram_index;
    logic                    data_we;
    logic [line_width-1:0]   data_wdata;
    logic [line_width-1:0]   data_rdata;
    logic                    tag_we;
    logic [tag_width-1:0]    tag_wdata;
    logic [tag_width-1:0]    tag_rdata;
    logic                    vd_we;
    logic                    vd_valid_in;
    logic                    vd_dirty_in;
    logic                    line_valid;
    logic                    line_dirty;
    req_cmd_e                req_cmd_q;
    amo_op_e                 req_amo_q;
    logic [sel_width-1:0]    word_sel;
    logic [word_width-1:0]   wdata_q;
    logic [word_width/8-1:0] wstrb_q;
    logic [word_width-1:0]   old_word;
    logic [line_width-1:0]   new_line;

    dcache_ctrl #(
        .addr_width (addr_width),
        .word_width (word_width),
        .line_words (line_words),
        .num_lines  (num_lines)
    ) u_ctrl (
        .CLK              (CLK),
        .RST              (RST),
        .req_valid        (req_valid),
        .req_cmd          (req_cmd),
        .req_amo          (req_amo),
        .req_addr         (req_addr),
        .req_wdata        (req_wdata),
        .req_wstrb        (req_wstrb),
        .tag_rdata        (tag_rdata),
        .line_valid       (line_valid),
        .line_dirty       (line_dirty),
        .old_word         (old_word),
        .new_line         (new_line),
        .data_rdata       (data_rdata),
        .l2_wr_done       (l2_wr_done),
        .l2_rd_data_valid (l2_rd_data_valid),
        .l2_rd_data       (l2_rd_data),
        .ready            (ready),
        .rsp_valid        (rsp_valid),
        .rsp_data         (rsp_data),
        .ram_index        (ram_index),
        .data_we          (data_we),
        .data_wdata       (data_wdata),
        .tag_we           (tag_we),
        .tag_wdata        (tag_wdata),
        .vd_we            (vd_we),
        .vd_valid_in      (vd_valid_in),
        .vd_dirty_in      (vd_dirty_in),
        .l2_wr_valid      (l2_wr_valid),
        .l2_wr_addr       (l2_wr_addr),
        .l2_wr_data       (l2_wr_data),
        .l2_rd_valid      (l2_rd_valid),
        .l2_rd_addr       (l2_rd_addr),
        .req_cmd_q        (req_cmd_q),
        .req_amo_q        (req_amo_q),
        .word_sel         (word_sel),
        .wdata_q          (wdata_q),
        .wstrb_q          (wstrb_q)
    );

    // line store.
    dcache_sdp_ram #(
        .width (line_width),
        .depth (num_lines)
    ) u_data_ram (
        .CLK   (CLK),
        .we    (data_we),
        .waddr (ram_index),
        .wdata (data_wdata),
        .raddr (ram_index),
        .rdata (data_rdata)
    );

    // tag store.
    dcache_sdp_ram #(
        .width (tag_width),
        .depth (num_lines)
    ) u_tag_ram (
        .CLK   (CLK),
        .we    (tag_we),
        .waddr (ram_index),
        .wdata (tag_wdata),
        .raddr (ram_index),
        .rdata (tag_rdata)
    );

    dcache_valid_dirty #(
        .num_lines (num_lines)
    ) u_valid_dirty (
        .CLK        (CLK),
        .RST        (RST),
        .index      (ram_index),
        .we         (vd_we),
        .valid_in   (vd_valid_in),
        .dirty_in   (vd_dirty_in),
        .line_valid (line_valid),
        .line_dirty (line_dirty)
    );

    dcache_word_merge #(
        .word_width (word_width),
        .line_words (line_words)
    ) u_word_merge (
        .line_in  (data_rdata),
        .word_sel (word_sel),
        .cmd      (req_cmd_q),
        .amo      (req_amo_q),
        .wdata    (wdata_q),
        .wstrb    (wstrb_q),
        .old_word (old_word),
        .new_line (new_line)
    );

endmodule

//--- hw/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter int addr_width = 32,
    parameter int word_width = 32,
    parameter int line_words = 4,
    parameter int num_lines  = 64,
    localparam int offset_width = $clog2(line_words * word_width / 8),
    localparam int index_width  = $clog2(num_lines),
    localparam int tag_width    = addr_width - index_width - offset_width,
    localparam int line_width   = word_width * line_words,
    localparam int sel_width    = (line_words > 1) ? $clog2(line_words) : 1,
    localparam int byte_width   = $clog2(word_width / 8)
) (
    input  logic                           CLK,
    input  logic                           RST,
    input  logic                           req_valid,
    input  dcache_pkg::req_cmd_e           req_cmd,
    input  dcache_pkg::amo_op_e            req_amo,
    input  logic [addr_width-1:0]          req_addr,
    input  logic [word_width-1:0]          req_wdata,
    input  logic [word_width/8-1:0]        req_wstrb,
    input  logic [tag_width-1:0]           tag_rdata,
    input  logic                           line_valid,
    input  logic                           line_dirty,
    input  logic [word_width-1:0]          old_word,
    input  logic [line_width-1:0]          new_line,
    input  logic [line_width-1:0]          data_rdata,
    input  logic                           l2_wr_done,
    input  logic                           l2_rd_data_valid,
    input  logic [line_width-1:0]          l2_rd_data,
    output logic                           ready,
    output logic                           rsp_valid,
    output logic [word_width-1:0]          rsp_data,
    output logic [index_width-1:0]         ram_index,
    output logic                           data_we,
    output logic [line_width-1:0]          data_wdata,
    output logic                           tag_we,
    output logic [tag_width-1:0]           tag_wdata,
    output logic                           vd_we,
    output logic                           vd_valid_in,
    output logic                           vd_dirty_in,
    output logic                           l2_wr_valid,
    output logic [addr_width-offset_width-1:0] l2_wr_addr,
    output logic [line_width-1:0]          l2_wr_data,
    output logic                           l2_rd_valid,
    output logic [addr_width-offset_width-1:0] l2_rd_addr,
    output dcache_pkg::req_cmd_e           req_cmd_q,
    output dcache_pkg::amo_op_e            req_amo_q,
    output logic [sel_width-1:0]           word_sel,
    output logic [word_width-1:0]          wdata_q,
    output logic [word_width/8-1:0]        wstrb_q
);
    import dcache_pkg::*;

    ctrl_state_e           state;
    logic [addr_width-1:0] addr_q;
    logic [tag_width-1:0]  tag_q;
    logic                  hit;
    logic                  fill;
    logic                  wb_outstanding;

    assign tag_q     = addr_q[addr_width-1 -: tag_width];
    assign ram_index = addr_q[offset_width +: index_width];
    assign word_sel  = addr_q[byte_width +: sel_width];
    assign hit       = line_valid && (tag_rdata == tag_q);
    assign fill      = (state == st_fill_wait) && l2_rd_data_valid;

    assign ready       = (state == st_idle);
    assign l2_wr_valid = (state == st_wb_send);
    assign l2_rd_valid = (state == st_fill_req);
    assign l2_rd_addr  = addr_q[addr_width-1:offset_width];

    // array writes: refill, or merged line on a store/amo hit.
    assign data_we     = fill || (state == st_compare && hit && req_cmd_q != cmd_load);
    assign data_wdata  = fill ? l2_rd_data : new_line;
    assign tag_we      = fill;
    assign tag_wdata   = tag_q;
    assign vd_we       = data_we;
    assign vd_valid_in = 1'b1;
    assign vd_dirty_in = !fill;

    //////////////////////////////
    // request register
    //////////////////////////////

    always_ff @(posedge CLK) begin
        if (ready && req_valid) begin
            addr_q    <= req_addr;
            req_cmd_q <= req_cmd;
            req_amo_q <= req_amo;
            wdata_q   <= req_wdata;
            wstrb_q   <= req_wstrb;
        end
    end

    //////////////////////////////
    // state machine
    //////////////////////////////

    always_ff @(posedge CLK) begin
        if (RST) begin
            state          <= st_idle;
            rsp_valid      <= 1'b0;
            wb_outstanding <= 1'b0;
        end else begin
            rsp_valid <= (state == st_respond);
            if (l2_wr_valid) begin
                wb_outstanding <= 1'b1;
            end else if (l2_wr_done) begin
                wb_outstanding <= 1'b0;
            end
            case (state)
                st_idle:      if (req_valid) state <= st_read;
                st_read:      state <= st_compare;
                st_compare: begin
                    if (hit) begin
                        state <= st_respond;
                    end else if (line_valid && line_dirty) begin
                        state <= st_wb_send;
                    end else begin
                        state <= st_fill_req;
                    end
                end
                st_wb_send:   state <= st_wb_wait;
                st_wb_wait:   if (l2_wr_done) state <= st_fill_req;
                st_fill_req:  state <= st_fill_wait;
                // replay the lookup once the line is in.
                st_fill_wait: if (l2_rd_data_valid) state <= st_read;
                st_respond:   state <= st_idle;
            endcase
        end
    end

    // victim line and response word.
    always_ff @(posedge CLK) begin
        if (state == st_compare) begin
            l2_wr_addr <= {tag_rdata, ram_index};
            l2_wr_data <= data_rdata;
            if (hit) begin
                rsp_data <= old_word;
            end
        end
    end

    // no refill request until the victim is written.
    a_no_rd_during_wb: assert property (@(posedge CLK) disable iff (RST)
        l2_rd_valid |-> !wb_outstanding);

    a_rsp_after_busy: assert property (@(posedge CLK) disable iff (RST)
        $past(ready) |-> !rsp_valid);

endmodule

//--- hw/dcache_word_merge.sv
`timescale 1ns/1ps

module dcache_word_merge #(
    parameter int word_width = 32,
    parameter int line_words = 4,
    localparam int line_width = word_width * line_words,
    localparam int sel_width  = (line_words > 1) ? $clog2(line_words) : 1
) (
    input  logic [line_width-1:0]   line_in,
    input  logic [sel_width-1:0]    word_sel,
    input  dcache_pkg::req_cmd_e    cmd,
    input  dcache_pkg::amo_op_e     amo,
    input  logic [word_width-1:0]   wdata,
    input  logic [word_width/8-1:0] wstrb,
    output logic [word_width-1:0]   old_word,
    output logic [line_width-1:0]   new_line
);
    import dcache_pkg::*;

    logic [word_width-1:0] new_word;
    logic                  lt_signed;
    logic                  lt_unsigned;

    assign old_word    = line_in[word_sel*word_width +: word_width];
    assign lt_signed   = $signed(wdata) < $signed(old_word);
    assign lt_unsigned = wdata < old_word;

    //////////////////////////////
    // word update
    //////////////////////////////

    always_comb begin
        new_word = old_word;
        case (cmd)
            cmd_store: begin
                for (int i = 0; i < word_width / 8; i++) begin
                    if (wstrb[i]) begin
                        new_word[i*8 +: 8] = wdata[i*8 +: 8];
                    end
                end
            end
            cmd_amo: begin
                case (amo)
                    amo_swap: new_word = wdata;
                    amo_add:  new_word = old_word + wdata;
                    amo_and:  new_word = old_word & wdata;
                    amo_or:   new_word = old_word | wdata;
                    amo_xor:  new_word = old_word ^ wdata;
                    amo_min:  new_word = lt_signed ? wdata : old_word;
                    amo_max:  new_word = lt_signed ? old_word : wdata;
                    amo_minu: new_word = lt_unsigned ? wdata : old_word;
                    amo_maxu: new_word = lt_unsigned ? old_word : wdata;
                    default:  new_word = old_word;
                endcase
            end
            default: new_word = old_word;
        endcase
    end

    // put the word back into the line.
    always_comb begin
        new_line = line_in;
        new_line[word_sel*word_width +: word_width] = new_word;
    end

    // opcode comes straight from the core via the request register.
    always_comb begin
        if (cmd == cmd_amo) begin
            a_amo_legal: assert final (amo inside {amo_swap, amo_add, amo_and, amo_or,
                amo_xor, amo_min, amo_max, amo_minu, amo_maxu});
        end
    end

endmodule

//--- hw/dcache_valid_dirty.sv
`timescale 1ns/1ps

module dcache_valid_dirty #(
    parameter int num_lines = 64,
    localparam int index_width = $clog2(num_lines)
) (
    input  logic                   CLK,
    input  logic                   RST,
    input  logic [index_width-1:0] index,
    input  logic                   we,
    input  logic                   valid_in,
    input  logic                   dirty_in,
    output logic                   line_valid,
    output logic                   line_dirty
);

    logic [num_lines-1:0] valid_bits;
    logic [num_lines-1:0] dirty_bits;

    // flags in flops, so reset empties the whole cache.
    always_ff @(posedge CLK) begin
        if (RST) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (we) begin
            valid_bits[index] <= valid_in;
            dirty_bits[index] <= dirty_in;
        end
    end

    // registered read, same latency as the rams.
    always_ff @(posedge CLK) begin
        if (RST) begin
            line_valid <= 1'b0;
            line_dirty <= 1'b0;
        end else begin
            line_valid <= valid_bits[index];
            line_dirty <= dirty_bits[index];
        end
    end

endmodule

//--- hw/dcache_sdp_ram.sv
`timescale 1ns/1ps

module dcache_sdp_ram #(
    parameter int width = 32,
    parameter int depth = 64,
    localparam int aw = $clog2(depth)
) (
    input  logic             CLK,
    input  logic             we,
    input  logic [aw-1:0]    waddr,
    input  logic [width-1:0] wdata,
    input  logic [aw-1:0]    raddr,
    output logic [width-1:0] rdata
);

    logic [width-1:0] mem [depth];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read data one cycle after the address.
    always_ff @(posedge CLK) begin
        rdata <= mem[raddr];
    end

    a_waddr_range: assert property (@(posedge CLK)
        we |-> (waddr < depth));

endmodule

//--- hw/dcache_pkg.sv
package dcache_pkg;

    //////////////////////////////
    // request kinds
    //////////////////////////////

    typedef enum logic [1:0] {
        cmd_load  = 2'd0,
        cmd_store = 2'd1,
        cmd_amo   = 2'd2
    } req_cmd_e;

    //////////////////////////////
    // atomic operations
    //////////////////////////////

    typedef enum logic [3:0] {
        amo_swap = 4'd0,
        amo_add  = 4'd1,
        amo_and  = 4'd2,
        amo_or   = 4'd3,
        amo_xor  = 4'd4,
        amo_min  = 4'd5,
        amo_max  = 4'd6,
        amo_minu = 4'd7,
        amo_maxu = 4'd8
    } amo_op_e;

    //////////////////////////////
    // controller states
    //////////////////////////////

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_compare,
        st_wb_send,
        st_wb_wait,
        st_fill_req,
        st_fill_wait,
        st_respond
    } ctrl_state_e;

endpackage
